// ==== Bender.yml ====
package:
  name: astar_open_sort

sources:
  - include_dirs:
      - logic
    files:
      - logic/astar_pkg.sv
      - logic/open_list_if.sv
      - logic/open_list_store.sv
      - logic/octile_distance.sv
      - logic/path_cost.sv
      - logic/open_list_sorter.sv
      - logic/astar_open_sort.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/astar_open_sort_chk.sv
      - dv/astar_open_sort_tb.sv

// ==== dv/astar_open_sort_chk.sv ====
module astar_open_sort_chk
(
	input logic                   Clk,
	input logic                   Reset,
	input astar_pkg::sort_state_e state,
	input astar_pkg::index_t      pair_index,
	input astar_pkg::count_t      fill,
	input logic                   start,
	input logic                   out_of_order,
	input logic                   swap,
	input logic                   busy,
	input logic                   done
);

	// done is a one-cycle pulse.
	done_pulse : assert property (@(posedge Clk) disable iff (Reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// exchanges follow a compare that found the pair out of order, inside the list.
	swap_state : assert property (@(posedge Clk) disable iff (Reset)
		swap |-> (state == astar_pkg::SWAP) && $past(out_of_order)
			&& ((astar_pkg::count_t'(pair_index) + astar_pkg::count_t'(1)) < fill))
		else $error("swap strobe outside the SWAP state or beyond the filled list");

	// done ends a sort, or answers a start on a short list.
	busy_done : assert property (@(posedge Clk) disable iff (Reset)
		done |-> !busy
			&& ($past(busy) || ($past(start) && ($past(fill) < astar_pkg::count_t'(2)))))
		else $error("done without a finished sort, or busy and done high together");

endmodule

// ==== dv/astar_open_sort_tb.sv ====
`include "astar_defs.svh"

module astar_open_sort_tb;

	localparam int NUM_CASES = 7;
	localparam int MAX_LOAD = `LIST_DEPTH + 2;
	localparam int RESET_CYCLES = 16;
	localparam int SORT_LIMIT = `LIST_DEPTH * `LIST_DEPTH * 6;
	localparam int WATCHDOG_CYCLES = (NUM_CASES + 1) * SORT_LIMIT + RESET_CYCLES;

	// per case goal, start, entry count and writes during the sort.
	int case_goal_x [NUM_CASES] = '{200, 37, 10, 0, 1, 250, 3};
	int case_goal_y [NUM_CASES] = '{40, 90, 10, 0, 2, 5, 140};
	int case_start_x [NUM_CASES] = '{10, 180, 0, 0, 3, 20, 99};
	int case_start_y [NUM_CASES] = '{180, 12, 0, 0, 4, 230, 60};
	int case_count [NUM_CASES] = '{16, 16, 8, 7, 1, 18, 5};
	bit case_busy_wr [NUM_CASES] = '{0, 0, 0, 0, 0, 0, 1};
	astar_pkg::coord_t case_x [NUM_CASES][MAX_LOAD];
	astar_pkg::coord_t case_y [NUM_CASES][MAX_LOAD];
	astar_pkg::coord_t exp_x [`LIST_DEPTH];
	astar_pkg::coord_t exp_y [`LIST_DEPTH];
	int kept;
	int mismatches = 0;
	int other_errors = 0;
	integer seed = 32059;

	logic Clk = 1'b0;
	logic Reset;
	logic wr_en;
	astar_pkg::coord_t wr_x;
	astar_pkg::coord_t wr_y;
	logic clear;
	astar_pkg::coord_t goal_x;
	astar_pkg::coord_t goal_y;
	astar_pkg::coord_t start_x;
	astar_pkg::coord_t start_y;
	logic start;
	astar_pkg::index_t rd_index;
	astar_pkg::coord_t rd_x;
	astar_pkg::coord_t rd_y;
	logic busy;
	logic done;

	astar_open_sort i_dut (.*);

	bind open_list_sorter astar_open_sort_chk i_chk
	(
		.Clk          (Clk),
		.Reset        (Reset),
		.state        (state),
		.pair_index   (pair_index),
		.fill         (list.fill),
		.start        (start),
		.out_of_order (out_of_order),
		.swap         (list.swap),
		.busy         (busy),
		.done         (done)
	);

	always #4 Clk = ~Clk;

	task automatic step();
		@(posedge Clk);
		#1;
	endtask

	task automatic check_coord(input astar_pkg::coord_t got, want, input string what);
		if (got !== want)
		begin
			mismatches++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_flag(input logic got, want, input string what);
		if (got !== want)
		begin
			mismatches++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	// longer leg plus the scaled shorter leg.
	function automatic int octile_ref(input int ax, input int ay, input int bx, input int by);
		int dx;
		int dy;
		dx = (ax > bx) ? ax - bx : bx - ax;
		dy = (ay > by) ? ay - by : by - ay;
		if (dx < dy)
		begin
			return dy + ((dx * `DIAG_NUM) >> `DIAG_SHIFT);
		end
		return dx + ((dy * `DIAG_NUM) >> `DIAG_SHIFT);
	endfunction

	function automatic int cell_cost(input int c, input int x, input int y);
		return octile_ref(x, y, case_goal_x[c], case_goal_y[c])
			+ octile_ref(x, y, case_start_x[c], case_start_y[c]);
	endfunction

	// stable insertion sort gives the strict-greater bubble order.
	task automatic build_expected(input int c);
		int cost [`LIST_DEPTH];
		int j;
		int tmp;
		astar_pkg::coord_t tx;
		astar_pkg::coord_t ty;
		kept = (case_count[c] < `LIST_DEPTH) ? case_count[c] : `LIST_DEPTH;
		for (int i = 0; i < kept; i++)
		begin
			exp_x[i] = case_x[c][i];
			exp_y[i] = case_y[c][i];
			cost[i] = cell_cost(c, exp_x[i], exp_y[i]);
		end
		for (int i = 1; i < kept; i++)
		begin
			j = i;
			while (j > 0 && cost[j-1] > cost[j])
			begin
				tmp = cost[j];
				cost[j] = cost[j-1];
				cost[j-1] = tmp;
				tx = exp_x[j];
				ty = exp_y[j];
				exp_x[j] = exp_x[j-1];
				exp_y[j] = exp_y[j-1];
				exp_x[j-1] = tx;
				exp_y[j-1] = ty;
				j--;
			end
		end
	endtask

	task automatic fill_table();
		astar_pkg::coord_t dup_x [8] = '{5, 7, 3, 5, 2, 1, 5, 3};
		astar_pkg::coord_t dup_y [8] = '{5, 2, 3, 5, 7, 1, 5, 3};
		astar_pkg::coord_t ord_x [7] = '{0, 1, 2, 3, 5, 9, 20};
		astar_pkg::coord_t ord_y [7] = '{0, 0, 0, 1, 5, 0, 20};
		for (int c = 0; c < NUM_CASES; c++)
		begin
			for (int i = 0; i < MAX_LOAD; i++)
			begin
				case_x[c][i] = astar_pkg::coord_t'($random(seed));
				case_y[c][i] = astar_pkg::coord_t'($random(seed));
			end
		end
		// equal costs and duplicate cells.
		for (int i = 0; i < 8; i++)
		begin
			case_x[2][i] = dup_x[i];
			case_y[2][i] = dup_y[i];
		end
		// already in ascending cost.
		for (int i = 0; i < 7; i++)
		begin
			case_x[3][i] = ord_x[i];
			case_y[3][i] = ord_y[i];
		end
	endtask

	task automatic load_case(input int c);
		clear = 1'b1;
		goal_x = astar_pkg::coord_t'(case_goal_x[c]);
		goal_y = astar_pkg::coord_t'(case_goal_y[c]);
		start_x = astar_pkg::coord_t'(case_start_x[c]);
		start_y = astar_pkg::coord_t'(case_start_y[c]);
		step();
		clear = 1'b0;
		for (int i = 0; i < case_count[c]; i++)
		begin
			wr_en = 1'b1;
			wr_x = case_x[c][i];
			wr_y = case_y[c][i];
			step();
		end
		wr_en = 1'b0;
	endtask

	task automatic run_sort(input bit busy_writes);
		int n;
		start = 1'b1;
		step();
		start = 1'b0;
		if (kept >= 2)
		begin
			check_flag(busy, 1'b1, "busy after start");
		end
		// these land while the sorter is in DIST, COST and COMPARE.
		if (busy_writes && kept >= 2)
		begin
			wr_en = 1'b1;
			repeat (3)
			begin
				wr_x = astar_pkg::coord_t'($random(seed));
				wr_y = astar_pkg::coord_t'($random(seed));
				step();
			end
			wr_en = 1'b0;
		end
		n = 0;
		while (done !== 1'b1 && n < SORT_LIMIT)
		begin
			step();
			n++;
		end
		if (done !== 1'b1)
		begin
			other_errors++;
			$display("sort did not finish within %0d cycles", SORT_LIMIT);
		end
		else
		begin
			check_flag(busy, 1'b0, "busy while done");
			step();
			check_flag(done, 1'b0, "done after its pulse");
		end
	endtask

	task automatic check_case(input int c);
		for (int i = 0; i < kept; i++)
		begin
			rd_index = astar_pkg::index_t'(i);
			step();
			check_coord(rd_x, exp_x[i], $sformatf("case %0d entry %0d x", c, i));
			check_coord(rd_y, exp_y[i], $sformatf("case %0d entry %0d y", c, i));
		end
	endtask

	initial
	begin
		Reset = 1'b1;
		wr_en = 1'b0;
		wr_x = '0;
		wr_y = '0;
		clear = 1'b0;
		goal_x = '0;
		goal_y = '0;
		start_x = '0;
		start_y = '0;
		start = 1'b0;
		rd_index = '0;
		fill_table();
		repeat (RESET_CYCLES) @(posedge Clk);
		#1;
		Reset = 1'b0;
		step();
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(done, 1'b0, "done after reset");
		// empty list answers with a single done pulse.
		kept = 0;
		run_sort(1'b0);
		for (int c = 0; c < NUM_CASES; c++)
		begin
			load_case(c);
			build_expected(c);
			run_sort(case_busy_wr[c]);
			check_case(c);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
		begin
			$display("RESULT: PASS");
		end
		else
		begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge Clk);
		$display("watchdog expired after %0d cycles, the sort never finished", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+logic
logic/astar_pkg.sv
logic/open_list_if.sv
logic/open_list_store.sv
logic/octile_distance.sv
logic/path_cost.sv
logic/open_list_sorter.sv
logic/astar_open_sort.sv
dv/astar_open_sort_chk.sv
dv/astar_open_sort_tb.sv

// ==== logic/astar_defs.svh ====
`ifndef ASTAR_DEFS_SVH
`define ASTAR_DEFS_SVH

// grid coordinate width.
`define COORD_W 8

// open list size and its index and count widths.
`define LIST_DEPTH 16
`define INDEX_W 4
`define COUNT_W 5

// wide enough for the sum of two octile distances.
`define COST_W 11

// diagonal factor, 106/256 is close to 0.414.
`define DIAG_NUM 106
`define DIAG_SHIFT 8

`endif

// ==== logic/astar_open_sort.sv ====
module astar_open_sort
(
	input  logic              Clk,
	input  logic              Reset,
	input  logic              wr_en,
	input  astar_pkg::coord_t wr_x,
	input  astar_pkg::coord_t wr_y,
	input  logic              clear,
	input  astar_pkg::coord_t goal_x,
	input  astar_pkg::coord_t goal_y,
	input  astar_pkg::coord_t start_x,
	input  astar_pkg::coord_t start_y,
	input  logic              start,
	input  astar_pkg::index_t rd_index,
	output astar_pkg::coord_t rd_x,
	output astar_pkg::coord_t rd_y,
	output logic              busy,
	output logic              done
);

	astar_pkg::cost_t goal_a;
	astar_pkg::cost_t goal_b;
	astar_pkg::cost_t start_a;
	astar_pkg::cost_t start_b;
	logic             out_of_order;

	open_list_if list_if ();

	open_list_store i_store
	(
		.Clk      (Clk),
		.Reset    (Reset),
		.wr_en    (wr_en),
		.wr_x     (wr_x),
		.wr_y     (wr_y),
		.clear    (clear),
		.busy     (busy),
		.rd_index (rd_index),
		.rd_x     (rd_x),
		.rd_y     (rd_y),
		.list     (list_if.store)
	);

	// distance to the goal cell.
	octile_distance i_goal_dist
	(
		.Clk    (Clk),
		.Reset  (Reset),
		.ref_x  (goal_x),
		.ref_y  (goal_y),
		.a_x    (list_if.a_x),
		.a_y    (list_if.a_y),
		.b_x    (list_if.b_x),
		.b_y    (list_if.b_y),
		.dist_a (goal_a),
		.dist_b (goal_b)
	);

	// distance back to the start cell.
	octile_distance i_start_dist
	(
		.Clk    (Clk),
		.Reset  (Reset),
		.ref_x  (start_x),
		.ref_y  (start_y),
		.a_x    (list_if.a_x),
		.a_y    (list_if.a_y),
		.b_x    (list_if.b_x),
		.b_y    (list_if.b_y),
		.dist_a (start_a),
		.dist_b (start_b)
	);

	path_cost i_cost
	(
		.Clk          (Clk),
		.Reset        (Reset),
		.goal_a       (goal_a),
		.goal_b       (goal_b),
		.start_a      (start_a),
		.start_b      (start_b),
		.out_of_order (out_of_order)
	);

	open_list_sorter i_sorter
	(
		.Clk          (Clk),
		.Reset        (Reset),
		.start        (start),
		.out_of_order (out_of_order),
		.busy         (busy),
		.done         (done),
		.list         (list_if.ctrl)
	);

endmodule

// ==== logic/astar_pkg.sv ====
`include "astar_defs.svh"

package astar_pkg;

	typedef logic [`COORD_W-1:0] coord_t;

	typedef logic [`INDEX_W-1:0] index_t;

	typedef logic [`COUNT_W-1:0] count_t;

	typedef logic [`COST_W-1:0] cost_t;

	// one compare step runs DIST, COST, COMPARE, optional SWAP, NEXT.
	typedef enum logic [2:0]
	{
		IDLE,
		DIST,
		COST,
		COMPARE,
		SWAP,
		NEXT,
		DONE
	} sort_state_e;

endpackage

// ==== logic/octile_distance.sv ====
`include "astar_defs.svh"

module octile_distance
(
	input  logic              Clk,
	input  logic              Reset,
	input  astar_pkg::coord_t ref_x,
	input  astar_pkg::coord_t ref_y,
	input  astar_pkg::coord_t a_x,
	input  astar_pkg::coord_t a_y,
	input  astar_pkg::coord_t b_x,
	input  astar_pkg::coord_t b_y,
	output astar_pkg::cost_t  dist_a,
	output astar_pkg::cost_t  dist_b
);

	// DIAG_NUM is below 2**DIAG_SHIFT so the product fits.
	localparam int PROD_W = `COORD_W + `DIAG_SHIFT;

	function automatic astar_pkg::cost_t octile
	(
		input astar_pkg::coord_t px,
		input astar_pkg::coord_t py,
		input astar_pkg::coord_t rx,
		input astar_pkg::coord_t ry
	);
		astar_pkg::coord_t dx;
		astar_pkg::coord_t dy;
		astar_pkg::coord_t long_leg;
		astar_pkg::coord_t short_leg;
		logic [PROD_W-1:0] scaled;
		dx = (px > rx) ? px - rx : rx - px;
		dy = (py > ry) ? py - ry : ry - py;
		long_leg = (dx > dy) ? dx : dy;
		short_leg = (dx > dy) ? dy : dx;
		scaled = PROD_W'(short_leg) * PROD_W'(`DIAG_NUM);
		return astar_pkg::cost_t'(long_leg) + astar_pkg::cost_t'(scaled >> `DIAG_SHIFT);
	endfunction

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			dist_a <= '0;
			dist_b <= '0;
		end
		else
		begin
			dist_a <= octile(a_x, a_y, ref_x, ref_y);
			dist_b <= octile(b_x, b_y, ref_x, ref_y);
		end
	end

endmodule

// ==== logic/open_list_if.sv ====
interface open_list_if;

	// pair under test is pair_index and pair_index+1.
	astar_pkg::index_t pair_index;
	logic              swap;

	astar_pkg::coord_t a_x;
	astar_pkg::coord_t a_y;
	astar_pkg::coord_t b_x;
	astar_pkg::coord_t b_y;

	astar_pkg::count_t fill;

	modport ctrl
	(
		output pair_index,
		output swap,
		input  fill
	);

	modport store
	(
		input  pair_index,
		input  swap,
		output a_x,
		output a_y,
		output b_x,
		output b_y,
		output fill
	);

endinterface

// ==== logic/open_list_sorter.sv ====
module open_list_sorter
(
	input  logic      Clk,
	input  logic      Reset,
	input  logic      start,
	input  logic      out_of_order,
	output logic      busy,
	output logic      done,
	open_list_if.ctrl list
);

	astar_pkg::sort_state_e state;
	astar_pkg::index_t      pair_index;
	astar_pkg::count_t      last_pair;
	logic                   pass_swapped;
	logic                   pass_end;

	// last pair of a pass starts at fill-2.
	assign last_pair = list.fill - astar_pkg::count_t'(2);
	assign pass_end = astar_pkg::count_t'(pair_index) == last_pair;

	assign list.pair_index = pair_index;
	assign list.swap = state == astar_pkg::SWAP;

	assign busy = (state != astar_pkg::IDLE) && (state != astar_pkg::DONE);
	assign done = state == astar_pkg::DONE;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= astar_pkg::IDLE;
			pair_index <= '0;
			pass_swapped <= 1'b0;
		end
		else
		begin
			case (state)
				astar_pkg::IDLE:
				begin
					if (start)
					begin
						pair_index <= '0;
						pass_swapped <= 1'b0;
						// nothing to order below two entries.
						if (list.fill < astar_pkg::count_t'(2))
						begin
							state <= astar_pkg::DONE;
						end
						else
						begin
							state <= astar_pkg::DIST;
						end
					end
				end
				astar_pkg::DIST:
				begin
					state <= astar_pkg::COST;
				end
				astar_pkg::COST:
				begin
					state <= astar_pkg::COMPARE;
				end
				astar_pkg::COMPARE:
				begin
					if (out_of_order)
					begin
						state <= astar_pkg::SWAP;
					end
					else
					begin
						state <= astar_pkg::NEXT;
					end
				end
				astar_pkg::SWAP:
				begin
					pass_swapped <= 1'b1;
					state <= astar_pkg::NEXT;
				end
				astar_pkg::NEXT:
				begin
					if (!pass_end)
					begin
						pair_index <= pair_index + astar_pkg::index_t'(1);
						state <= astar_pkg::DIST;
					end
					else if (pass_swapped)
					begin
						// another pass from the head.
						pair_index <= '0;
						pass_swapped <= 1'b0;
						state <= astar_pkg::DIST;
					end
					else
					begin
						state <= astar_pkg::DONE;
					end
				end
				astar_pkg::DONE:
				begin
					state <= astar_pkg::IDLE;
				end
				default:
				begin
					state <= astar_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/open_list_store.sv ====
`include "astar_defs.svh"

module open_list_store
(
	input  logic              Clk,
	input  logic              Reset,
	input  logic              wr_en,
	input  astar_pkg::coord_t wr_x,
	input  astar_pkg::coord_t wr_y,
	input  logic              clear,
	input  logic              busy,
	input  astar_pkg::index_t rd_index,
	output astar_pkg::coord_t rd_x,
	output astar_pkg::coord_t rd_y,
	open_list_if.store        list
);

	astar_pkg::coord_t x_mem [`LIST_DEPTH];
	astar_pkg::coord_t y_mem [`LIST_DEPTH];
	astar_pkg::count_t fill;
	astar_pkg::index_t next_index;
	astar_pkg::index_t wr_index;
	logic              append;
	logic              empty_list;

	// clear beats a write in the same cycle.
	assign empty_list = clear && !busy;
	assign append = wr_en && !busy && !clear && (fill < `LIST_DEPTH);

	assign wr_index = astar_pkg::index_t'(fill);
	assign next_index = list.pair_index + astar_pkg::index_t'(1);

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			fill <= '0;
		end
		else if (empty_list)
		begin
			fill <= '0;
		end
		else if (append)
		begin
			fill <= fill + astar_pkg::count_t'(1);
		end
	end

	// writes only when idle, swaps only while sorting.
	always_ff @(posedge Clk)
	begin
		if (append)
		begin
			x_mem[wr_index] <= wr_x;
			y_mem[wr_index] <= wr_y;
		end
		else if (list.swap)
		begin
			x_mem[list.pair_index] <= list.b_x;
			y_mem[list.pair_index] <= list.b_y;
			x_mem[next_index] <= list.a_x;
			y_mem[next_index] <= list.a_y;
		end
	end

	assign list.a_x = x_mem[list.pair_index];
	assign list.a_y = y_mem[list.pair_index];
	assign list.b_x = x_mem[next_index];
	assign list.b_y = y_mem[next_index];
	assign list.fill = fill;

	assign rd_x = x_mem[rd_index];
	assign rd_y = y_mem[rd_index];

endmodule

// ==== logic/path_cost.sv ====
module path_cost
(
	input  logic             Clk,
	input  logic             Reset,
	input  astar_pkg::cost_t goal_a,
	input  astar_pkg::cost_t goal_b,
	input  astar_pkg::cost_t start_a,
	input  astar_pkg::cost_t start_b,
	output logic             out_of_order
);

	astar_pkg::cost_t cost_a;
	astar_pkg::cost_t cost_b;

	// sums cannot overflow, two distances of at most 360 each.
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			cost_a <= '0;
			cost_b <= '0;
		end
		else
		begin
			cost_a <= goal_a + start_a;
			cost_b <= goal_b + start_b;
		end
	end

	// strict compare keeps equal costs in load order.
	assign out_of_order = cost_a > cost_b;

endmodule
